//--- design/sss_settings.svh
`ifndef SSS_SETTINGS_SVH
`define SSS_SETTINGS_SVH

// length of one SSS sequence and of each m-sequence
`define SSS_LEN          127
// soft sample width coming out of the FFT
`define SSS_SAMPLE_W     12
// n_id_1 candidates, split into three groups of 112 cyclic shifts
`define SSS_N_ID_1_CNT   336
`define SSS_SHIFT_CNT    112

// m-sequence generators, x^7 + x^4 + 1 and x^7 + x + 1
`define SSS_LFSR_N       7
`define SSS_TAPS_0       7'h11
`define SSS_TAPS_1       7'h03
`define SSS_LFSR_START   7'h01

`endif

//--- design/sss_pkg.sv
`include "sss_settings.svh"

package sss_pkg;

    // soft sample as delivered by the FFT
    typedef logic signed [`SSS_SAMPLE_W-1:0] sample_t;

    // sector identity from the PSS stage
    typedef logic [1:0] n_id_2_t;

    // group identity, 0 to 335
    typedef logic [$clog2(`SSS_N_ID_1_CNT)-1:0] n_id_1_t;

    // cell identity, 3 * n_id_1 + n_id_2 tops out at 1007
    typedef logic [9:0] n_id_t;

    // absolute correlation over one sequence, 0 to 127
    typedef logic [$clog2(`SSS_LEN+1)-1:0] metric_t;

endpackage

//--- design/lfsr.sv
`timescale 1ns/10ps
`include "sss_settings.svh"

module lfsr #(
    parameter int             N           = `SSS_LFSR_N,
    parameter logic [N-1:0]   TAPS        = `SSS_TAPS_0,
    parameter logic [N-1:0]   START_VALUE = `SSS_LFSR_START
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic data_o,
    output logic valid_o
);

    // index of the last cycle of the first period
    localparam logic [N-1:0] LAST_CYCLE = N'((1 << N) - 2);

    logic [N-1:0] state_q;
    logic [N-1:0] cycle_q;
    logic         valid_q;

    // state_q[k] holds x(i+k), the oldest bit leaves at position 0
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= START_VALUE;
            cycle_q <= '0;
            valid_q <= 1'b1;
        end else begin
            state_q <= {^(state_q & TAPS), state_q[N-1:1]};
            if (valid_q) begin
                cycle_q <= cycle_q + 1'b1;
                if (cycle_q == LAST_CYCLE) begin
                    valid_q <= 1'b0;
                end
            end
        end
    end

    assign data_o  = state_q[0];
    assign valid_o = valid_q;

endmodule

//--- design/sss_slicer.sv
`timescale 1ns/10ps
`include "sss_settings.svh"

module sss_slicer (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  sss_pkg::sample_t sample_i,
    input  logic             sample_valid_i,
    input  logic             frame_start_i,
    output logic             bit_o,
    output logic             bit_valid_o
);

    localparam logic [6:0] LAST_BIT = 7'(`SSS_LEN - 1);

    logic       armed_q;
    logic [6:0] bit_cnt_q;

    // frame counter, a start strobe always wins over a sample in the same cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            armed_q     <= 1'b0;
            bit_cnt_q   <= '0;
            bit_valid_o <= 1'b0;
        end else begin
            bit_valid_o <= 1'b0;
            if (frame_start_i) begin
                armed_q   <= 1'b1;
                bit_cnt_q <= '0;
            end else if (sample_valid_i && armed_q) begin
                bit_valid_o <= 1'b1;
                bit_cnt_q   <= bit_cnt_q + 7'd1;
                // disarm after the last bit, further samples are dropped
                if (bit_cnt_q == LAST_BIT) begin
                    armed_q <= 1'b0;
                end
            end
        end
    end

    // sign decision, non-negative maps to symbol +1 which is bit 1
    always_ff @(posedge clk_i) begin
        if (sample_valid_i && armed_q && !frame_start_i) begin
            bit_o <= ~sample_i[`SSS_SAMPLE_W-1];
        end
    end

endmodule

//--- design/sss_detector.sv
`timescale 1ns/10ps
`include "sss_settings.svh"

module sss_detector (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  logic             bit_i,
    input  logic             bit_valid_i,
    input  sss_pkg::n_id_2_t n_id_2_i,
    input  logic             n_id_2_valid_i,
    output sss_pkg::n_id_1_t n_id_1_o,
    output sss_pkg::metric_t metric_o,
    output logic             done_o
);

    localparam logic [6:0]       LAST_POS   = 7'(`SSS_LEN - 1);
    localparam logic [6:0]       EVAL_CNT   = 7'(`SSS_LEN);
    localparam logic [6:0]       LAST_SHIFT = 7'(`SSS_SHIFT_CNT - 1);
    localparam sss_pkg::n_id_1_t LAST_ID    = sss_pkg::n_id_1_t'(`SSS_N_ID_1_CNT - 1);

    // small lookup tables in place of the multiplications
    function automatic logic [6:0] times_5(input sss_pkg::n_id_2_t n);
        case (n)
            2'd1:    times_5 = 7'd5;
            2'd2:    times_5 = 7'd10;
            default: times_5 = 7'd0;
        endcase
    endfunction

    function automatic logic [6:0] times_15(input logic [1:0] g);
        case (g)
            2'd1:    times_15 = 7'd15;
            2'd2:    times_15 = 7'd30;
            default: times_15 = 7'd0;
        endcase
    endfunction

    logic                  lfsr_bit_0;
    logic                  lfsr_bit_1;
    logic                  lfsr_valid_0;
    logic                  lfsr_valid_1;
    logic [`SSS_LEN-1:0]   m_seq_0;
    logic [`SSS_LEN-1:0]   m_seq_1;
    logic [`SSS_LEN-1:0]   frame_q;

    logic                  busy_q;
    logic [6:0]            bit_cnt_q;
    sss_pkg::n_id_2_t      n_id_2_q;
    logic [6:0]            cnt_q;
    logic [6:0]            shift_q;
    logic [1:0]            group_q;
    sss_pkg::n_id_1_t      cand_q;
    logic                  wrap_0_q;
    logic                  wrap_1_q;
    logic signed [7:0]     acc_q;
    sss_pkg::metric_t      best_metric_q;
    sss_pkg::n_id_1_t      best_id_q;

    logic [6:0]            m_0;
    logic [6:0]            pos_0;
    logic [6:0]            pos_1;
    logic                  match;
    logic                  start_search;
    logic                  eval;
    logic                  last_cand;
    sss_pkg::metric_t      abs_acc;
    logic                  take;
    sss_pkg::metric_t      next_metric;
    sss_pkg::n_id_1_t      next_id;

    lfsr #(
        .N           (`SSS_LFSR_N),
        .TAPS        (`SSS_TAPS_0),
        .START_VALUE (`SSS_LFSR_START)
    ) lfsr_0 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .data_o   (lfsr_bit_0),
        .valid_o  (lfsr_valid_0)
    );

    lfsr #(
        .N           (`SSS_LFSR_N),
        .TAPS        (`SSS_TAPS_1),
        .START_VALUE (`SSS_LFSR_START)
    ) lfsr_1 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .data_o   (lfsr_bit_1),
        .valid_o  (lfsr_valid_1)
    );

    // m_0 = 15 * (n_id_1 / 112) + 5 * n_id_2, m_1 = n_id_1 % 112
    assign m_0 = times_15(group_q) + times_5(n_id_2_q);

    // 7-bit overflow plus the wrap flag gives the index modulo 127
    assign pos_0 = m_0 + cnt_q + {6'd0, wrap_0_q};
    assign pos_1 = shift_q + cnt_q + {6'd0, wrap_1_q};

    assign match = frame_q[cnt_q] == ~(m_seq_0[pos_0] ^ m_seq_1[pos_1]);

    assign start_search = !busy_q && bit_valid_i && (bit_cnt_q == LAST_POS);
    assign eval         = busy_q && (cnt_q == EVAL_CNT);
    assign last_cand    = cand_q == LAST_ID;

    assign abs_acc     = acc_q[7] ? 7'(-acc_q) : acc_q[6:0];
    // strictly greater, so the lowest n_id_1 keeps a tie
    assign take        = abs_acc > best_metric_q;
    assign next_metric = take ? abs_acc : best_metric_q;
    assign next_id     = take ? cand_q : best_id_q;

    // both generators run in step for one period right after reset
    always_ff @(posedge clk_i) begin
        if (lfsr_valid_0 && lfsr_valid_1) begin
            m_seq_0 <= {lfsr_bit_0, m_seq_0[`SSS_LEN-1:1]};
            m_seq_1 <= {lfsr_bit_1, m_seq_1[`SSS_LEN-1:1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busy_q && bit_valid_i) begin
            frame_q[bit_cnt_q] <= bit_i;
        end
    end

    // candidate sequencing, 127 compare cycles and one evaluate cycle each
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            busy_q    <= 1'b0;
            bit_cnt_q <= '0;
            n_id_2_q  <= '0;
            cnt_q     <= '0;
            shift_q   <= '0;
            group_q   <= '0;
            cand_q    <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (!busy_q) begin
                if (n_id_2_valid_i) begin
                    n_id_2_q <= n_id_2_i;
                end
                if (bit_valid_i) begin
                    if (bit_cnt_q == LAST_POS) begin
                        bit_cnt_q <= '0;
                        busy_q    <= 1'b1;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 7'd1;
                    end
                end
            end else if (eval) begin
                cnt_q <= '0;
                if (last_cand) begin
                    busy_q  <= 1'b0;
                    done_o  <= 1'b1;
                    cand_q  <= '0;
                    shift_q <= '0;
                    group_q <= '0;
                end else begin
                    cand_q <= cand_q + 1'b1;
                    if (shift_q == LAST_SHIFT) begin
                        shift_q <= '0;
                        group_q <= group_q + 2'd1;
                    end else begin
                        shift_q <= shift_q + 7'd1;
                    end
                end
            end else begin
                cnt_q <= cnt_q + 7'd1;
            end
        end
    end

    // correlation and running maximum
    always_ff @(posedge clk_i) begin
        if (start_search) begin
            acc_q         <= '0;
            wrap_0_q      <= 1'b0;
            wrap_1_q      <= 1'b0;
            best_metric_q <= '0;
            best_id_q     <= '0;
        end else if (eval) begin
            acc_q         <= '0;
            wrap_0_q      <= 1'b0;
            wrap_1_q      <= 1'b0;
            best_metric_q <= next_metric;
            best_id_q     <= next_id;
            if (last_cand) begin
                n_id_1_o <= next_id;
                metric_o <= next_metric;
            end
        end else if (busy_q) begin
            acc_q <= match ? acc_q + 8'sd1 : acc_q - 8'sd1;
            if (pos_0 == LAST_POS) begin
                wrap_0_q <= 1'b1;
            end
            if (pos_1 == LAST_POS) begin
                wrap_1_q <= 1'b1;
            end
        end
    end

endmodule

//--- design/cell_id_report.sv
`timescale 1ns/10ps

module cell_id_report (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  sss_pkg::n_id_2_t n_id_2_i,
    input  logic             n_id_2_valid_i,
    input  sss_pkg::n_id_1_t n_id_1_i,
    input  sss_pkg::metric_t metric_i,
    input  logic             done_i,
    output sss_pkg::n_id_t   n_id_o,
    output sss_pkg::n_id_1_t n_id_1_o,
    output sss_pkg::metric_t metric_o,
    output logic             id_valid_o
);

    sss_pkg::n_id_2_t n_id_2_q;
    sss_pkg::n_id_t   n_id_next;

    // 3 * n_id_1 + n_id_2 as a shift and two adds
    assign n_id_next = {n_id_1_i, 1'b0} + {1'b0, n_id_1_i} + {8'd0, n_id_2_q};

    // a new sector strobe starts a new search, so the old result goes stale
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_id_2_q   <= '0;
            id_valid_o <= 1'b0;
        end else begin
            if (n_id_2_valid_i) begin
                n_id_2_q <= n_id_2_i;
            end
            if (done_i) begin
                id_valid_o <= 1'b1;
            end else if (n_id_2_valid_i) begin
                id_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (done_i) begin
            n_id_o   <= n_id_next;
            n_id_1_o <= n_id_1_i;
            metric_o <= metric_i;
        end
    end

endmodule

//--- design/sss_top.sv
`timescale 1ns/10ps
`include "sss_settings.svh"

module sss_top (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  sss_pkg::sample_t sample_i,
    input  logic             sample_valid_i,
    input  logic             frame_start_i,
    input  sss_pkg::n_id_2_t n_id_2_i,
    input  logic             n_id_2_valid_i,
    output sss_pkg::n_id_t   n_id_o,
    output sss_pkg::n_id_1_t n_id_1_o,
    output sss_pkg::metric_t metric_o,
    output logic             id_valid_o
);

    logic             bit_w;
    logic             bit_valid_w;
    sss_pkg::n_id_1_t det_n_id_1_w;
    sss_pkg::metric_t det_metric_w;
    logic             det_done_w;

    sss_slicer u_slicer (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .frame_start_i  (frame_start_i),
        .bit_o          (bit_w),
        .bit_valid_o    (bit_valid_w)
    );

    // n_id_2 goes to both, the detector needs it for the m_0 offset
    sss_detector u_detector (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .bit_i          (bit_w),
        .bit_valid_i    (bit_valid_w),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .n_id_1_o       (det_n_id_1_w),
        .metric_o       (det_metric_w),
        .done_o         (det_done_w)
    );

    cell_id_report u_report (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .n_id_1_i       (det_n_id_1_w),
        .metric_i       (det_metric_w),
        .done_i         (det_done_w),
        .n_id_o         (n_id_o),
        .n_id_1_o       (n_id_1_o),
        .metric_o       (metric_o),
        .id_valid_o     (id_valid_o)
    );

endmodule

//--- tb/sss_sva.sv
`timescale 1ns/10ps
`include "sss_settings.svh"

module sss_sva (
    input logic           clk_i,
    input logic           reset_ni,
    input logic           frame_start_i,
    input logic           sample_valid_i,
    input logic           bit_valid_i,
    input logic           done_i,
    input logic           id_valid_i,
    input sss_pkg::n_id_t n_id_i
);

    logic       armed_q;
    logic [7:0] cnt_q;
    int         fail_cnt = 0;

    // frame window as seen from the top-level strobes
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            armed_q <= 1'b0;
            cnt_q   <= '0;
        end else if (frame_start_i) begin
            armed_q <= 1'b1;
            cnt_q   <= '0;
        end else if (sample_valid_i && armed_q) begin
            cnt_q <= cnt_q + 8'd1;
            if (cnt_q == 8'(`SSS_LEN - 1)) begin
                armed_q <= 1'b0;
            end
        end
    end

    done_then_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        done_i |=> id_valid_i)
        else begin
            fail_cnt++;
            $error("id_valid_o did not follow done_o");
        end

    bit_only_when_armed: assert property (@(posedge clk_i) disable iff (!reset_ni)
        bit_valid_i |-> $past(armed_q && sample_valid_i && !frame_start_i))
        else begin
            fail_cnt++;
            $error("bit_valid_o outside an armed frame");
        end

    n_id_in_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        id_valid_i |-> (n_id_i < 10'd1008))
        else begin
            fail_cnt++;
            $error("n_id_o out of range");
        end

endmodule

//--- tb/sss_checker.sv
`timescale 1ns/10ps
`include "sss_settings.svh"

module sss_checker (
    input  logic             clk_i,
    input  logic             reset_ni,
    input  logic             sample_valid_i,
    input  logic             frame_start_i,
    input  logic             n_id_2_valid_i,
    input  logic             id_valid_i,
    input  sss_pkg::n_id_t   n_id_i,
    input  sss_pkg::n_id_1_t n_id_1_i,
    input  sss_pkg::metric_t metric_i,
    input  logic             exp_valid_i,
    input  int               exp_index_i,
    input  int               exp_n_id_2_i,
    input  int               exp_n_id_1_i,
    input  int               exp_n_id_i,
    input  int               exp_flips_i,
    output int               value_errors_o,
    output int               other_errors_o,
    output int               result_cnt_o
);

    // 336 candidates of 128 cycles, one cycle in the slicer, one in the reporter
    localparam int RISE_CYCLES = 336 * 128 + 2;
    // sampled on the falling edge, half a cycle on either side adds one
    localparam int RISE_DIST   = RISE_CYCLES + 1;

    int   cycle;
    int   last_cycle;
    int   sample_cnt;
    int   index;
    int   n_id_2;
    int   n_id_1;
    int   n_id;
    int   flips;
    logic pending;
    logic armed;
    logic got_last;
    logic id_valid_q;
    logic clear_wait;

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Fail %s expected %0d actual %0d", name, expected, actual);
            value_errors_o++;
        end
    endtask

    task automatic check_result();
        string tag;
        tag = $sformatf("vector %0d", index);
        if (!pending) begin
            $display("%s: id_valid_o rose with no frame pending", tag);
            other_errors_o++;
        end else if (!got_last) begin
            $display("%s: id_valid_o rose before all samples were sent", tag);
            other_errors_o++;
        end else begin
            check_value({tag, " latency"}, RISE_DIST, cycle - last_cycle);
            check_value({tag, " n_id_1"}, n_id_1, int'(n_id_1_i));
            check_value({tag, " n_id"}, n_id, int'(n_id_i));
            // identity rule applied independently of the file column
            check_value({tag, " n_id rule"}, 3 * n_id_1 + n_id_2, int'(n_id_i));
            check_value({tag, " metric"}, `SSS_LEN - 2 * flips, int'(metric_i));
            result_cnt_o++;
            pending = 1'b0;
        end
    endtask

    always @(negedge clk_i) begin
        if (!reset_ni) begin
            value_errors_o = 0;
            other_errors_o = 0;
            result_cnt_o   = 0;
            cycle          = 0;
            last_cycle     = 0;
            sample_cnt     = 0;
            pending        = 1'b0;
            armed          = 1'b0;
            got_last       = 1'b0;
            id_valid_q     = 1'b0;
            clear_wait     = 1'b0;
        end else begin
            cycle++;
            if (clear_wait) begin
                if (id_valid_i) begin
                    $display("vector %0d: id_valid_o stayed high after an n_id_2 strobe", index);
                    other_errors_o++;
                end
                clear_wait = 1'b0;
            end
            if (n_id_2_valid_i && id_valid_i) begin
                clear_wait = 1'b1;
            end
            if (exp_valid_i) begin
                index    = exp_index_i;
                n_id_2   = exp_n_id_2_i;
                n_id_1   = exp_n_id_1_i;
                n_id     = exp_n_id_i;
                flips    = exp_flips_i;
                pending  = 1'b1;
                armed    = 1'b0;
                got_last = 1'b0;
            end
            // only the first whole frame after the expectation counts
            if (frame_start_i && pending && !got_last) begin
                armed      = 1'b1;
                sample_cnt = 0;
            end else if (sample_valid_i && armed) begin
                sample_cnt++;
                if (sample_cnt == `SSS_LEN) begin
                    last_cycle = cycle;
                    got_last   = 1'b1;
                    armed      = 1'b0;
                end
            end
            if (id_valid_i && !id_valid_q) begin
                check_result();
            end
            id_valid_q = id_valid_i;
        end
    end

endmodule

//--- tb/sss_tb.sv
`timescale 1ns/10ps
`include "sss_settings.svh"

module sss_tb;

    localparam int MAX_VECTORS       = 64;
    localparam int FIELDS            = 5;
    localparam int CYCLES_PER_VECTOR = 43200;

    logic             clk_i;
    logic             reset_ni;
    sss_pkg::sample_t sample_i;
    logic             sample_valid_i;
    logic             frame_start_i;
    sss_pkg::n_id_2_t n_id_2_i;
    logic             n_id_2_valid_i;
    sss_pkg::n_id_t   n_id_o;
    sss_pkg::n_id_1_t n_id_1_o;
    sss_pkg::metric_t metric_o;
    logic             id_valid_o;

    // per vector: n_id_2, n_id_1, n_id, flip mask, flip count
    logic [127:0] pattern_mem [0:MAX_VECTORS*FIELDS-1];
    int   vector_cnt;
    int   seed;
    logic loaded;
    logic exp_valid;
    int   exp_index;
    int   exp_n_id_2;
    int   exp_n_id_1;
    int   exp_n_id;
    int   exp_flips;
    int   value_errors;
    int   other_errors;
    int   result_cnt;
    int   setup_errors;
    int   assert_errors;

    sss_top uut (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .frame_start_i  (frame_start_i),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .n_id_o         (n_id_o),
        .n_id_1_o       (n_id_1_o),
        .metric_o       (metric_o),
        .id_valid_o     (id_valid_o)
    );

    sss_checker u_checker (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .frame_start_i  (frame_start_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .id_valid_i     (id_valid_o),
        .n_id_i         (n_id_o),
        .n_id_1_i       (n_id_1_o),
        .metric_i       (metric_o),
        .exp_valid_i    (exp_valid),
        .exp_index_i    (exp_index),
        .exp_n_id_2_i   (exp_n_id_2),
        .exp_n_id_1_i   (exp_n_id_1),
        .exp_n_id_i     (exp_n_id),
        .exp_flips_i    (exp_flips),
        .value_errors_o (value_errors),
        .other_errors_o (other_errors),
        .result_cnt_o   (result_cnt)
    );

    bind sss_top sss_sva u_sva (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .frame_start_i  (frame_start_i),
        .sample_valid_i (sample_valid_i),
        .bit_valid_i    (bit_valid_w),
        .done_i         (det_done_w),
        .id_valid_i     (id_valid_o),
        .n_id_i         (n_id_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // SSS from the two m-sequence recurrences, bit 1 stands for symbol +1
    function automatic logic [`SSS_LEN-1:0] build_sss_bits(input int n2, input int n1);
        logic [`SSS_LEN-1:0] x0;
        logic [`SSS_LEN-1:0] x1;
        logic [`SSS_LEN-1:0] d;
        int                  m0;
        int                  m1;
        x0    = '0;
        x1    = '0;
        x0[0] = 1'b1;
        x1[0] = 1'b1;
        for (int i = 0; i < `SSS_LEN - 7; i++) begin
            x0[i+7] = x0[i+4] ^ x0[i];
            x1[i+7] = x1[i+1] ^ x1[i];
        end
        m0 = 15 * (n1 / 112) + 5 * n2;
        m1 = n1 % 112;
        for (int n = 0; n < `SSS_LEN; n++) begin
            d[n] = x0[(n + m0) % `SSS_LEN] == x1[(n + m1) % `SSS_LEN];
        end
        return d;
    endfunction

    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    // random amplitude, sign carries the bit
    task automatic set_sample(input logic b);
        int amp;
        amp            = int'($unsigned($random(seed)) % 2047) + 1;
        sample_valid_i = 1'b1;
        sample_i       = b ? sss_pkg::sample_t'(amp) : sss_pkg::sample_t'(-amp);
    endtask

    task automatic run_vector(input int v);
        logic [`SSS_LEN-1:0] bits;
        int                  base;
        base       = v * FIELDS;
        exp_index  = v;
        exp_n_id_2 = int'(pattern_mem[base][1:0]);
        exp_n_id_1 = int'(pattern_mem[base+1][8:0]);
        exp_n_id   = int'(pattern_mem[base+2][9:0]);
        exp_flips  = int'(pattern_mem[base+4][7:0]);
        bits = build_sss_bits(exp_n_id_2, exp_n_id_1) ^ pattern_mem[base+3][`SSS_LEN-1:0];
        n_id_2_i       = sss_pkg::n_id_2_t'(exp_n_id_2);
        n_id_2_valid_i = 1'b1;
        exp_valid      = 1'b1;
        step();
        n_id_2_valid_i = 1'b0;
        exp_valid      = 1'b0;
        frame_start_i  = 1'b1;
        step();
        frame_start_i = 1'b0;
        for (int i = 0; i < `SSS_LEN; i++) begin
            set_sample(bits[i]);
            step();
        end
        // strobes past the frame end are dropped by the slicer
        for (int i = 0; i < 5; i++) begin
            set_sample(1'($random(seed)));
            step();
        end
        sample_valid_i = 1'b0;
        repeat (20) step();
        // a whole new frame and a sector strobe while the search runs
        frame_start_i = 1'b1;
        step();
        frame_start_i = 1'b0;
        for (int i = 0; i < 20; i++) begin
            set_sample(1'($random(seed)));
            step();
        end
        sample_valid_i = 1'b0;
        n_id_2_valid_i = 1'b1;
        step();
        n_id_2_valid_i = 1'b0;
        while (!id_valid_o) begin
            step();
        end
        repeat (3) step();
    endtask

    initial begin
        seed           = 4;
        loaded         = 1'b0;
        reset_ni       = 1'b0;
        sample_i       = '0;
        sample_valid_i = 1'b0;
        frame_start_i  = 1'b0;
        n_id_2_i       = '0;
        n_id_2_valid_i = 1'b0;
        exp_valid      = 1'b0;
        exp_index      = 0;
        exp_n_id_2     = 0;
        exp_n_id_1     = 0;
        exp_n_id       = 0;
        exp_flips      = 0;
        setup_errors   = 0;
        assert_errors  = 0;
        vector_cnt     = 0;
        $readmemh("tb/sss_patterns.hex", pattern_mem);
        while (vector_cnt < MAX_VECTORS && !$isunknown(pattern_mem[vector_cnt*FIELDS])) begin
            vector_cnt++;
        end
        loaded = 1'b1;
        if (vector_cnt == 0) begin
            $display("no test vectors were read from the pattern file");
            setup_errors++;
        end
        repeat (5) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;
        // sequence registers fill during the first 127 cycles
        repeat (200) step();
        for (int v = 0; v < vector_cnt; v++) begin
            run_vector(v);
        end
        // one last sector strobe so the final result is seen to clear
        n_id_2_valid_i = 1'b1;
        step();
        n_id_2_valid_i = 1'b0;
        repeat (5) step();
        if (result_cnt != vector_cnt) begin
            $display("only %0d of %0d results were reported", result_cnt, vector_cnt);
            setup_errors++;
        end
        assert_errors = uut.u_sva.fail_cnt;
        $display("results %0d, value errors %0d, other errors %0d, assertion errors %0d",
                 result_cnt, value_errors, other_errors + setup_errors, assert_errors);
        if (value_errors + other_errors + setup_errors + assert_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (vector_cnt * CYCLES_PER_VECTOR + 1000) @(posedge clk_i);
        $display("timeout: no result from the DUT within the expected run time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- tb/sss_patterns.hex
// n_id_2  n_id_1  n_id  flip mask (bit n inverts sample n)  flip count
// all fields in hex, one vector per line
0 0 0 0 0
0 6f 14d 0 0
0 70 150 0 0
0 14f 3ed 0 0
0 c8 258 0 0
1 0 1 0 0
1 6f 14e 0 0
1 70 151 0 0
1 14f 3ee 0 0
1 c8 259 0 0
2 0 2 0 0
2 6f 14f 0 0
2 70 152 0 0
2 14f 3ef 0 0
2 c8 25a 0 0
1 39 ac 1f 5
2 12c 386 100000000000000080000000000007f0 9
0 96 1c2 40000000000000000000000000000000 1

//--- vlog.f
+incdir+design
design/sss_pkg.sv
design/lfsr.sv
design/sss_slicer.sv
design/sss_detector.sv
design/cell_id_report.sv
design/sss_top.sv
tb/sss_sva.sv
tb/sss_checker.sv
tb/sss_tb.sv

//--- Makefile
SIM      = verilator
TOP      = sss_tb
FILELIST = vlog.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) design/sss_settings.svh
PASS     = ALL TESTS PASSED

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)
